// File: rtl/host_cfg_pkg.sv
package host_cfg_pkg;

    // ------------------------------
    // stream geometry
    // ------------------------------

    // host to core beat, 64 bits wide
    localparam int DATA_WID = 64;

    // one enable per data byte
    localparam int KEEP_WID = DATA_WID / 8;

    // host queue id, carried in tid on the host side
    localparam int QID_WID = 12;

    // ------------------------------
    // host functions
    // ------------------------------

    // PF plus three VFs
    localparam int NUM_FUNC = 4;

    // out-of-range packet counter, saturating
    localparam int DROP_CNT_WID = 16;

endpackage : host_cfg_pkg

// File: rtl/host_types_pkg.sv
package host_types_pkg;

    import host_cfg_pkg::*;

    // ------------------------------
    // function type
    // ------------------------------

    // encoding that replaces the queue id in tid after the filter
    typedef enum logic [1:0] {
        PF  = 2'd0,
        VF0 = 2'd1,
        VF1 = 2'd2,
        VF2 = 2'd3
    } func_typ_t;

    // host queue id and the window config values
    typedef logic [QID_WID-1:0] qid_t;

    // ------------------------------
    // beat payloads
    // ------------------------------

    // classified beat, as stored by the register slice ahead of the demux
    typedef struct packed {
        logic [DATA_WID-1:0] data;
        logic [KEEP_WID-1:0] keep;
        logic                last;
        func_typ_t           tid;
    } raw_beat_t;

endpackage : host_types_pkg

// File: rtl/host_q_classify.sv
module host_q_classify
    import host_cfg_pkg::*;
    import host_types_pkg::*;
(
    input  logic                core_clk,
    input  logic                core_rstn,

    // host side, tid holds the queue id
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [DATA_WID-1:0] in_data,
    input  logic [KEEP_WID-1:0] in_keep,
    input  logic                in_last,
    input  qid_t                in_qid,

    // static queue windows, one per function
    input  qid_t                q_base [NUM_FUNC],
    input  qid_t                q_num  [NUM_FUNC],

    // registered beat plus window hits
    output logic                out_valid,
    input  logic                out_ready,
    output logic [DATA_WID-1:0] out_data,
    output logic [KEEP_WID-1:0] out_keep,
    output logic                out_last,
    output logic [NUM_FUNC-1:0] out_hit
);

    logic [NUM_FUNC-1:0] hit_nxt;
    logic                accept;

    // ------------------------------
    // window compares
    // ------------------------------

    // half-open window, end computed one bit wider so base + num cannot wrap
    for (genvar j = 0; j < NUM_FUNC; j++) begin : g_win
        logic [QID_WID:0] win_end;

        assign win_end    = {1'b0, q_base[j]} + {1'b0, q_num[j]};
        assign hit_nxt[j] = (in_qid >= q_base[j]) && ({1'b0, in_qid} < win_end);
    end

    // ------------------------------
    // output register
    // ------------------------------

    // room when empty or when the held beat leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload and compare results, loaded on accept only
    always_ff @(posedge core_clk) begin
        if (accept) begin
            out_data <= in_data;
            out_keep <= in_keep;
            out_last <= in_last;
            out_hit  <= hit_nxt;
        end
    end

    // stalled beat must stay put until the filter takes it
    a_hold_stable : assert property (
        @(posedge core_clk) disable iff (!core_rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
                                    && $stable(out_last) && $stable(out_hit)
    );

endmodule : host_q_classify

// File: rtl/host_q_filter.sv
module host_q_filter
    import host_cfg_pkg::*;
    import host_types_pkg::*;
(
    input  logic                    core_clk,
    input  logic                    core_rstn,

    // from classify
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [DATA_WID-1:0]     in_data,
    input  logic [KEEP_WID-1:0]     in_keep,
    input  logic                    in_last,
    input  logic [NUM_FUNC-1:0]     in_hit,

    // kept beats with the function type in tid
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [DATA_WID-1:0]     out_data,
    output logic [KEEP_WID-1:0]     out_keep,
    output logic                    out_last,
    output func_typ_t               out_func,

    output logic [DROP_CNT_WID-1:0] drop_cnt
);

    logic any_hit;
    logic drop_eop;

    // ------------------------------
    // gate and encode
    // ------------------------------

    assign any_hit = |in_hit;

    // dropped beats are consumed at the downstream ready and never shown
    assign in_ready  = out_ready;
    assign out_valid = in_valid && any_hit;
    assign out_data  = in_data;
    assign out_keep  = in_keep;
    assign out_last  = in_last;

    // lowest window wins on overlap so the scan runs downwards
    always_comb begin
        out_func = PF;
        for (int j = NUM_FUNC - 1; j >= 0; j--) begin
            if (in_hit[j]) begin
                out_func = func_typ_t'(j[$bits(func_typ_t)-1:0]);
            end
        end
    end

    // ------------------------------
    // drop counter
    // ------------------------------

    // one count per packet at its last beat
    assign drop_eop = in_valid && in_ready && !any_hit && in_last;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            drop_cnt <= '0;
        end else if (drop_eop && (drop_cnt != '1)) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end

    // hits come registered from classify so no X may reach the encode
    a_func_known : assert property (
        @(posedge core_clk) disable iff (!core_rstn)
        out_valid |-> !$isunknown(in_hit) && in_hit[out_func]
    );

endmodule : host_q_filter

// File: rtl/axis_reg_slice.sv
module axis_reg_slice #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     core_clk,
    input  logic     core_rstn,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    logic accept;

    // ------------------------------
    // single entry, full rate
    // ------------------------------

    // a new beat may enter in the cycle the held one leaves
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload only, valid above carries the state
    always_ff @(posedge core_clk) begin
        if (accept) begin
            out_payload <= in_payload;
        end
    end

endmodule : axis_reg_slice

// File: rtl/host_func_demux.sv
module host_func_demux
    import host_cfg_pkg::*;
    import host_types_pkg::*;
(
    input  logic                core_clk,
    input  logic                core_rstn,

    // classified stream from the slice
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [DATA_WID-1:0] in_data,
    input  logic [KEEP_WID-1:0] in_keep,
    input  logic                in_last,
    input  func_typ_t           in_func,

    // PF, VF0 and VF1 share this output
    output logic                pfvf_valid,
    input  logic                pfvf_ready,
    output logic [DATA_WID-1:0] pfvf_data,
    output logic [KEEP_WID-1:0] pfvf_keep,
    output logic                pfvf_last,
    output func_typ_t           pfvf_func,

    // VF2 only
    output logic                vf2_valid,
    input  logic                vf2_ready,
    output logic [DATA_WID-1:0] vf2_data,
    output logic [KEEP_WID-1:0] vf2_keep,
    output logic                vf2_last
);

    logic sop;
    logic sel_vf2;
    logic route_vf2;
    logic accept;

    // ------------------------------
    // packet tracking
    // ------------------------------

    // first beat decides and later beats follow the latched side
    assign route_vf2 = sop ? (in_func == VF2) : sel_vf2;

    // at most one side holds a beat so this is the held side's ready
    assign in_ready = (!pfvf_valid || pfvf_ready) && (!vf2_valid || vf2_ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            sop        <= 1'b1;
            sel_vf2    <= 1'b0;
            pfvf_valid <= 1'b0;
            vf2_valid  <= 1'b0;
        end else begin
            if (accept) begin
                sop     <= in_last;
                sel_vf2 <= route_vf2;
            end
            if (accept && !route_vf2) begin
                pfvf_valid <= 1'b1;
            end else if (pfvf_ready) begin
                pfvf_valid <= 1'b0;
            end
            if (accept && route_vf2) begin
                vf2_valid <= 1'b1;
            end else if (vf2_ready) begin
                vf2_valid <= 1'b0;
            end
        end
    end

    // ------------------------------
    // output registers
    // ------------------------------

    // only the selected side loads
    always_ff @(posedge core_clk) begin
        if (accept && !route_vf2) begin
            pfvf_data <= in_data;
            pfvf_keep <= in_keep;
            pfvf_last <= in_last;
            pfvf_func <= in_func;
        end
        if (accept && route_vf2) begin
            vf2_data <= in_data;
            vf2_keep <= in_keep;
            vf2_last <= in_last;
        end
    end

    // beats inside a packet land on the latched side only
    a_sel_locked : assert property (
        @(posedge core_clk) disable iff (!core_rstn)
        accept && !sop |=> (sel_vf2 ? (vf2_valid && !pfvf_valid) : (pfvf_valid && !vf2_valid))
    );

endmodule : host_func_demux

// File: rtl/host_ingress.sv
module host_ingress
    import host_cfg_pkg::*;
    import host_types_pkg::*;
(
    input  logic                    core_clk,
    input  logic                    core_rstn,

    // host stream, tid is the queue id
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [DATA_WID-1:0]     in_data,
    input  logic [KEEP_WID-1:0]     in_keep,
    input  logic                    in_last,
    input  qid_t                    in_qid,

    // queue windows per function
    input  qid_t                    q_base [NUM_FUNC],
    input  qid_t                    q_num  [NUM_FUNC],

    output logic [DROP_CNT_WID-1:0] drop_cnt,

    output logic                    pfvf_valid,
    input  logic                    pfvf_ready,
    output logic [DATA_WID-1:0]     pfvf_data,
    output logic [KEEP_WID-1:0]     pfvf_keep,
    output logic                    pfvf_last,
    output func_typ_t               pfvf_func,

    output logic                    vf2_valid,
    input  logic                    vf2_ready,
    output logic [DATA_WID-1:0]     vf2_data,
    output logic [KEEP_WID-1:0]     vf2_keep,
    output logic                    vf2_last
);

    // classify to filter
    logic                cls_valid;
    logic                cls_ready;
    logic [DATA_WID-1:0] cls_data;
    logic [KEEP_WID-1:0] cls_keep;
    logic                cls_last;
    logic [NUM_FUNC-1:0] cls_hit;

    // filter to slice, slice to demux
    logic                flt_valid;
    logic                flt_ready;
    raw_beat_t           flt_beat;
    logic                slc_valid;
    logic                slc_ready;
    raw_beat_t           slc_beat;

    // ------------------------------
    // stages
    // ------------------------------

    host_q_classify host_q_classify_i (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_qid    (in_qid),
        .q_base    (q_base),
        .q_num     (q_num),
        .out_valid (cls_valid),
        .out_ready (cls_ready),
        .out_data  (cls_data),
        .out_keep  (cls_keep),
        .out_last  (cls_last),
        .out_hit   (cls_hit)
    );

    // outputs land straight in the slice payload fields
    host_q_filter host_q_filter_i (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .in_valid  (cls_valid),
        .in_ready  (cls_ready),
        .in_data   (cls_data),
        .in_keep   (cls_keep),
        .in_last   (cls_last),
        .in_hit    (cls_hit),
        .out_valid (flt_valid),
        .out_ready (flt_ready),
        .out_data  (flt_beat.data),
        .out_keep  (flt_beat.keep),
        .out_last  (flt_beat.last),
        .out_func  (flt_beat.tid),
        .drop_cnt  (drop_cnt)
    );

    axis_reg_slice #(
        .payload_t (raw_beat_t)
    ) axis_reg_slice_i (
        .core_clk    (core_clk),
        .core_rstn   (core_rstn),
        .in_valid    (flt_valid),
        .in_ready    (flt_ready),
        .in_payload  (flt_beat),
        .out_valid   (slc_valid),
        .out_ready   (slc_ready),
        .out_payload (slc_beat)
    );

    host_func_demux host_func_demux_i (
        .core_clk   (core_clk),
        .core_rstn  (core_rstn),
        .in_valid   (slc_valid),
        .in_ready   (slc_ready),
        .in_data    (slc_beat.data),
        .in_keep    (slc_beat.keep),
        .in_last    (slc_beat.last),
        .in_func    (slc_beat.tid),
        .pfvf_valid (pfvf_valid),
        .pfvf_ready (pfvf_ready),
        .pfvf_data  (pfvf_data),
        .pfvf_keep  (pfvf_keep),
        .pfvf_last  (pfvf_last),
        .pfvf_func  (pfvf_func),
        .vf2_valid  (vf2_valid),
        .vf2_ready  (vf2_ready),
        .vf2_data   (vf2_data),
        .vf2_keep   (vf2_keep),
        .vf2_last   (vf2_last)
    );

endmodule : host_ingress

// File: sim/tb_clk_gen.sv
module tb_clk_gen (
    output logic core_clk,
    output logic core_rstn
);

    // 4 unit period
    initial begin
        core_clk = 1'b0;
        forever #2 core_clk = ~core_clk;
    end

    // low for 16 rising edges, released just after the last one
    initial begin
        core_rstn = 1'b0;
        repeat (16) @(posedge core_clk);
        #1 core_rstn = 1'b1;
    end

endmodule : tb_clk_gen

// File: sim/host_ingress_checker.sv
module host_ingress_checker
    import host_cfg_pkg::*;
    import host_types_pkg::*;
(
    input  logic                    core_clk,
    input  logic                    core_rstn,
    input  logic                    in_valid,
    input  logic                    in_ready,
    input  logic [DATA_WID-1:0]     in_data,
    input  logic [KEEP_WID-1:0]     in_keep,
    input  logic                    in_last,
    input  qid_t                    in_qid,
    input  qid_t                    q_base [NUM_FUNC],
    input  qid_t                    q_num  [NUM_FUNC],
    input  logic [DROP_CNT_WID-1:0] drop_cnt,
    input  logic                    pfvf_valid,
    input  logic                    pfvf_ready,
    input  logic [DATA_WID-1:0]     pfvf_data,
    input  logic [KEEP_WID-1:0]     pfvf_keep,
    input  logic                    pfvf_last,
    input  func_typ_t               pfvf_func,
    input  logic                    vf2_valid,
    input  logic                    vf2_ready,
    input  logic [DATA_WID-1:0]     vf2_data,
    input  logic [KEEP_WID-1:0]     vf2_keep,
    input  logic                    vf2_last,
    input  logic                    fixed_rdy,
    input  logic                    end_chk,
    output logic                    drained,
    output int                      val_errs,
    output int                      other_errs
);

    // expected beat, tagged with its acceptance cycle
    typedef struct packed {
        logic [DATA_WID-1:0] data;
        logic [KEEP_WID-1:0] keep;
        logic                last;
        logic [1:0]          func;
        logic                timed;
        int                  cyc;
    } exp_beat_t;

    exp_beat_t pfvf_q [$];
    exp_beat_t vf2_q  [$];
    int        cyc;
    int        exp_drop;
    logic      was_rst;

    // owning function of a queue id, lowest window first, -1 when none
    function automatic int owner(input qid_t qid);
        for (int j = 0; j < NUM_FUNC; j++) begin
            if (int'(qid) >= int'(q_base[j]) && int'(qid) < int'(q_base[j]) + int'(q_num[j])) begin
                return j;
            end
        end
        return -1;
    endfunction

    task automatic compare(input string port, input exp_beat_t want, input exp_beat_t got);
        if (got.data !== want.data || got.keep !== want.keep || got.last !== want.last
            || got.func !== want.func) begin
            val_errs++;
            $display("FAIL %0t: %s beat got %h/%h/%b/%0d exp %h/%h/%b/%0d", $time, port,
                     got.data, got.keep, got.last, got.func,
                     want.data, want.keep, want.last, want.func);
        end
        // with all readys high the path is a plain 3 stage pipe
        if (want.timed && fixed_rdy && (got.cyc - want.cyc != 3)) begin
            val_errs++;
            $display("FAIL %0t: %s latency %0d cycles, exp 3", $time, port, got.cyc - want.cyc);
        end
    endtask

    // ------------------------------
    // model and compare
    // ------------------------------

    always @(posedge core_clk) begin
        exp_beat_t b;
        int        f;
        if (!core_rstn) begin
            was_rst    = 1'b1;
            drained    = 1'b0;
            val_errs   = 0;
            other_errs = 0;
            cyc        = 0;
            exp_drop   = 0;
        end else begin
            if (was_rst && (pfvf_valid || vf2_valid || drop_cnt != 0)) begin
                other_errs++;
                $display("outputs were not idle right after reset, at time %0t", $time);
            end
            was_rst = 1'b0;
            cyc++;
            if (in_valid && in_ready) begin
                f = owner(in_qid);
                b = '{in_data, in_keep, in_last, f[1:0], fixed_rdy, cyc};
                if (f < 0) begin
                    exp_drop += int'(in_last);
                end else if (f == 3) begin
                    vf2_q.push_back(b);
                end else begin
                    pfvf_q.push_back(b);
                end
            end
            if (pfvf_valid && pfvf_ready) begin
                if (pfvf_q.size() == 0) begin
                    other_errs++;
                    $display("pfvf output gave a beat nobody sent, at time %0t", $time);
                end else begin
                    compare("pfvf", pfvf_q.pop_front(),
                            '{pfvf_data, pfvf_keep, pfvf_last, pfvf_func, 1'b0, cyc});
                end
            end
            if (vf2_valid && vf2_ready) begin
                if (vf2_q.size() == 0) begin
                    other_errs++;
                    $display("vf2 output gave a beat nobody sent, at time %0t", $time);
                end else begin
                    compare("vf2", vf2_q.pop_front(), '{vf2_data, vf2_keep, vf2_last, 2'd3, 1'b0, cyc});
                end
            end
            if (end_chk) begin
                if (pfvf_q.size() + vf2_q.size() != 0) begin
                    other_errs++;
                    $display("%0d beats never left the DUT", pfvf_q.size() + vf2_q.size());
                end
                if (int'(drop_cnt) != exp_drop) begin
                    val_errs++;
                    $display("FAIL %0t: drop_cnt %0d exp %0d", $time, drop_cnt, exp_drop);
                end
            end
            drained = (pfvf_q.size() == 0) && (vf2_q.size() == 0) && (int'(drop_cnt) >= exp_drop);
        end
    end

endmodule : host_ingress_checker

// File: sim/host_ingress_tb.sv
module host_ingress_tb
    import host_cfg_pkg::*;
    import host_types_pkg::*;
();

    localparam int NUM_PKT = 16;

    // one row per packet: queue id, beat count, data seed
    localparam int PKT_QID   [NUM_PKT] = '{3, 20, 49, 120, 200, 15, 16, 47,
                                           48, 50, 100, 163, 164, 99, 0, 4095};
    localparam int PKT_BEATS [NUM_PKT] = '{1, 3, 2, 4, 2, 1, 1, 2, 1, 1, 3, 1, 2, 1, 5, 1};
    localparam int PKT_SEED  [NUM_PKT] = '{'h1a2b, 'h3c4d, 'h5e6f, 'h7081, 'h92a3, 'hb4c5,
                                           'hd6e7, 'hf809, 'h0123, 'h4567, 'h89ab, 'hcdef,
                                           'h2468, 'h1357, 'h0ace, 'hbdf0};

    logic                    core_clk;
    logic                    core_rstn;
    logic                    in_valid;
    logic                    in_ready;
    logic [DATA_WID-1:0]     in_data;
    logic [KEEP_WID-1:0]     in_keep;
    logic                    in_last;
    qid_t                    in_qid;
    qid_t                    q_base [NUM_FUNC];
    qid_t                    q_num  [NUM_FUNC];
    logic [DROP_CNT_WID-1:0] drop_cnt;
    logic                    pfvf_valid;
    logic                    pfvf_ready;
    logic [DATA_WID-1:0]     pfvf_data;
    logic [KEEP_WID-1:0]     pfvf_keep;
    logic                    pfvf_last;
    func_typ_t               pfvf_func;
    logic                    vf2_valid;
    logic                    vf2_ready;
    logic [DATA_WID-1:0]     vf2_data;
    logic [KEEP_WID-1:0]     vf2_keep;
    logic                    vf2_last;
    logic                    fixed_rdy;
    logic                    rand_rdy;
    logic                    end_chk;
    logic                    drained;
    int                      val_errs;
    int                      other_errs;
    logic [31:0]             rng;
    int                      cyc_cnt;
    int                      timeout_cyc;

    tb_clk_gen tb_clk_gen_i (.core_clk(core_clk), .core_rstn(core_rstn));

    host_ingress host_ingress_i (.*);

    host_ingress_checker host_ingress_checker_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one table row, each beat held until the DUT takes it
    task automatic send_packet(input int idx);
        logic taken;
        for (int k = 0; k < PKT_BEATS[idx]; k++) begin
            in_valid = 1'b1;
            in_qid   = qid_t'(PKT_QID[idx]);
            in_last  = (k == PKT_BEATS[idx] - 1);
            in_data  = {PKT_SEED[idx], 16'(k), 4'h0, in_qid};
            in_keep  = in_last ? ({KEEP_WID{1'b1}} >> PKT_SEED[idx][2:0]) : {KEEP_WID{1'b1}};
            do begin
                @(negedge core_clk);
                taken = in_ready;
                @(posedge core_clk);
                #1;
            end while (!taken);
        end
        in_valid = 1'b0;
    endtask

    task automatic run_table();
        for (int i = 0; i < NUM_PKT; i++) begin
            send_packet(i);
        end
        do begin
            @(posedge core_clk);
            #1;
        end while (!drained);
    endtask

    // ------------------------------
    // back-pressure and watchdog
    // ------------------------------

    always @(posedge core_clk) begin
        #1;
        if (rand_rdy) begin
            rng        = xorshift32(rng);
            pfvf_ready = rng[0] | rng[1];
            vf2_ready  = rng[7];
        end
    end

    always @(posedge core_clk) begin
        cyc_cnt = cyc_cnt + 1;
        if (cyc_cnt == timeout_cyc) begin
            $display("timeout, outputs did not drain");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        // three passes over the table
        timeout_cyc = 200;
        for (int i = 0; i < NUM_PKT; i++) begin
            timeout_cyc += 3 * 8 * PKT_BEATS[i];
        end
        cyc_cnt    = 0;
        rng        = 32'd17;
        in_valid   = 1'b0;
        in_data    = '0;
        in_keep    = '0;
        in_last    = 1'b0;
        in_qid     = '0;
        pfvf_ready = 1'b1;
        vf2_ready  = 1'b1;
        fixed_rdy  = 1'b1;
        rand_rdy   = 1'b0;
        end_chk    = 1'b0;
        q_base     = '{0, 16, 48, 100};
        q_num      = '{16, 32, 2, 64};
        @(posedge core_rstn);
        @(posedge core_clk);
        #1;

        // readys high, exact latency
        run_table();
        // random back-pressure on both outputs
        fixed_rdy = 1'b0;
        rand_rdy  = 1'b1;
        run_table();
        // overlapping windows, PF over VF0 and VF0 over VF1
        q_num[0]  = 20;
        q_base[2] = 40;
        q_num[2]  = 10;
        run_table();

        end_chk = 1'b1;
        @(posedge core_clk);
        #1;
        end_chk = 1'b0;
        $display("errors: %0d wrong values, %0d other", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : host_ingress_tb

// File: compile.f
rtl/host_cfg_pkg.sv
rtl/host_types_pkg.sv
rtl/host_q_classify.sv
rtl/host_q_filter.sv
rtl/axis_reg_slice.sv
rtl/host_func_demux.sv
rtl/host_ingress.sv
sim/tb_clk_gen.sv
sim/host_ingress_checker.sv
sim/host_ingress_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f compile.f --top-module host_ingress_tb -o host_ingress_sim
	-./obj_dir/host_ingress_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
